//--- common/mcu_port_pkg.sv
package mcu_port_pkg;

    // Basic widths on the MCU side
    localparam int BYTE_W = 8;
    localparam int WORD_W = 16;
    localparam int SEL_W  = 6;

    typedef logic [BYTE_W-1:0] port_byte_t;
    typedef logic [WORD_W-1:0] mcu_word_t;
    typedef logic [SEL_W-1:0]  mcu_sel_t;

    // Port 2 bit map, strobes are active low
    localparam int P2_SEL2_BIT = 2;
    localparam int P2_ACK_BIT  = 3;
    localparam int P2_RDHI_BIT = 4;
    localparam int P2_RDLO_BIT = 5;
    localparam int P2_WRLO_BIT = 6;
    localparam int P2_WRHI_BIT = 7;

    // Select bus bit that requests the MCU interrupt
    localparam int SEL_IRQ_BIT = 0;

    // Select bits 5:3 land on port 3 bits 7:5
    localparam int SEL_P3_LSB   = 3;
    localparam int SEL_P3_WIDTH = 3;

    // Port 3 bits that loop back from the MCU's own outputs
    localparam int P3_OWN_W = 5;

    // INT1 pin levels, the 8751 input is active low
    localparam logic INT_ASSERTED = 1'b0;
    localparam logic INT_RELEASED = 1'b1;

endpackage

//--- common/cop_bank_pkg.sv
package cop_bank_pkg;

    // Bank flags driven by MCU port 1
    typedef logic [1:0] snd_flag_t;
    typedef logic [1:0] b1_flag_t;
    typedef logic [1:0] mix_flag_t;

    // Character bank from MCU port 3
    typedef logic [2:0] crback_t;

    // Status readout page, taken from the top of st_addr
    typedef logic [1:0] st_page_t;

    localparam int ST_PAGE_LSB = 6;

    localparam st_page_t PAGE_DOUT_LO = 2'd0;
    localparam st_page_t PAGE_DOUT_HI = 2'd1;
    localparam st_page_t PAGE_P0_IN   = 2'd2;
    localparam st_page_t PAGE_FLAGS   = 2'd3;

endpackage

//--- mcu_bridge/sel_irq.sv
`timescale 1ns/1ps

module sel_irq
    import mcu_port_pkg::*;
#(
    parameter int SYNC_STAGES = 1
) (
    input  logic clk,
    input  logic rst24,
    input  logic sel_irq_in,
    input  logic ack_n,
    output logic int1n
);

    logic sel_last;
    logic sel_l;

    // Optional synchronizer in front of the edge detector
    generate
        if (SYNC_STAGES > 0) begin : g_sync
            logic [SYNC_STAGES-1:0] sync_q;

            always_ff @(posedge clk or posedge rst24) begin
                if (rst24) begin
                    sync_q <= '0;
                end else begin
                    sync_q[0] <= sel_irq_in;
                    for (int i = 1; i < SYNC_STAGES; i++) begin
                        sync_q[i] <= sync_q[i-1];
                    end
                end
            end

            assign sel_last = sync_q[SYNC_STAGES-1];
        end else begin : g_nosync
            assign sel_last = sel_irq_in;
        end
    endgenerate

    // Rising edge sets the request, the MCU clears it via port 2
    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            sel_l <= 1'b0;
            int1n <= INT_RELEASED;
        end else begin
            sel_l <= sel_last;
            // Acknowledge has priority over a fresh edge
            if (!ack_n) begin
                int1n <= INT_RELEASED;
            end else if (sel_last && !sel_l) begin
                int1n <= INT_ASSERTED;
            end
        end
    end

endmodule

//--- mcu_bridge/byte_mailbox.sv
`timescale 1ns/1ps

module byte_mailbox
    import mcu_port_pkg::*;
(
    input  logic       clk,
    input  logic       rst24,
    input  port_byte_t p2_out,
    input  port_byte_t p0_out,
    input  mcu_word_t  mcu_din,
    output port_byte_t p0_in,
    output mcu_word_t  mcu_dout
);

    logic rd_hi;
    logic rd_lo;
    logic wr_hi;
    logic wr_lo;

    port_byte_t din_hi;
    port_byte_t din_lo;

    // Port 2 strobes are active low
    assign rd_hi = ~p2_out[P2_RDHI_BIT];
    assign rd_lo = ~p2_out[P2_RDLO_BIT];
    assign wr_hi = ~p2_out[P2_WRHI_BIT];
    assign wr_lo = ~p2_out[P2_WRLO_BIT];

    assign din_hi = mcu_din[WORD_W-1:BYTE_W];
    assign din_lo = mcu_din[BYTE_W-1:0];

    // Main CPU to MCU, one byte at a time into port 0
    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            p0_in <= '0;
        end else begin
            // Low byte wins if both strobes are down
            if (rd_lo) begin
                p0_in <= din_lo;
            end else if (rd_hi) begin
                p0_in <= din_hi;
            end
        end
    end

    // MCU to main CPU, halves written independently
    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            mcu_dout <= '0;
        end else begin
            if (wr_hi) begin
                mcu_dout[WORD_W-1:BYTE_W] <= p0_out;
            end
            if (wr_lo) begin
                mcu_dout[BYTE_W-1:0] <= p0_out;
            end
        end
    end

endmodule

//--- logic/status_dump.sv
`timescale 1ns/1ps

module status_dump
    import mcu_port_pkg::*, cop_bank_pkg::*;
(
    input  logic       clk,
    input  logic       rst24,
    input  port_byte_t st_addr,
    input  mcu_word_t  mcu_dout,
    input  port_byte_t p0_in,
    input  snd_flag_t  snd_flag,
    input  b1_flag_t   b1_flag,
    input  logic       b0_flag,
    input  mix_flag_t  mix_flag,
    output port_byte_t st_dout
);

    st_page_t   page;
    port_byte_t page_byte;

    // Page number sits in the top bits of the address
    assign page = st_addr[ST_PAGE_LSB +: $bits(st_page_t)];

    always_comb begin
        page_byte = '0;
        case (page)
            PAGE_DOUT_LO: page_byte = mcu_dout[BYTE_W-1:0];
            PAGE_DOUT_HI: page_byte = mcu_dout[WORD_W-1:BYTE_W];
            PAGE_P0_IN:   page_byte = p0_in;
            // Same layout as port 1, bit 7 reads as zero
            PAGE_FLAGS:   page_byte = {1'b0, snd_flag, b1_flag, b0_flag, mix_flag};
            default:      page_byte = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            st_dout <= '0;
        end else begin
            st_dout <= page_byte;
        end
    end

endmodule

//--- logic/cop_mcu_bridge.sv
`timescale 1ns/1ps

module cop_mcu_bridge
    import mcu_port_pkg::*, cop_bank_pkg::*;
#(
    parameter int SYNC_STAGES = 1
) (
    input  logic       clk,
    input  logic       rst24,
    // Main CPU side
    input  mcu_sel_t   mcu_sel,
    input  mcu_word_t  mcu_din,
    // MCU port outputs
    input  port_byte_t p0_out,
    input  port_byte_t p1_out,
    input  port_byte_t p2_out,
    input  port_byte_t p3_out,
    input  port_byte_t st_addr,
    // MCU inputs
    output logic       int1n,
    output port_byte_t p0_in,
    output port_byte_t p3_in,
    output mcu_word_t  mcu_dout,
    output logic       sel2,
    // ROM banking
    output snd_flag_t  snd_flag,
    output b1_flag_t   b1_flag,
    output logic       b0_flag,
    output mix_flag_t  mix_flag,
    output crback_t    crback,
    output port_byte_t st_dout
);

    // Port 1 carries the bank flags, bit 7 unused
    assign {snd_flag, b1_flag, b0_flag, mix_flag} = p1_out[6:0];

    assign crback = p3_out[$bits(crback_t)-1:0];

    // Port 3 input mixes select bits with the port's own outputs
    assign p3_in = {mcu_sel[SEL_P3_LSB +: SEL_P3_WIDTH], p3_out[P3_OWN_W-1:0]};

    assign sel2 = p2_out[P2_SEL2_BIT];

    sel_irq #(
        .SYNC_STAGES (SYNC_STAGES)
    ) irq_u (
        .clk        (clk),
        .rst24      (rst24),
        .sel_irq_in (mcu_sel[SEL_IRQ_BIT]),
        .ack_n      (p2_out[P2_ACK_BIT]),
        .int1n      (int1n)
    );

    byte_mailbox mailbox_u (
        .clk      (clk),
        .rst24    (rst24),
        .p2_out   (p2_out),
        .p0_out   (p0_out),
        .mcu_din  (mcu_din),
        .p0_in    (p0_in),
        .mcu_dout (mcu_dout)
    );

    status_dump status_u (
        .clk      (clk),
        .rst24    (rst24),
        .st_addr  (st_addr),
        .mcu_dout (mcu_dout),
        .p0_in    (p0_in),
        .snd_flag (snd_flag),
        .b1_flag  (b1_flag),
        .b0_flag  (b0_flag),
        .mix_flag (mix_flag),
        .st_dout  (st_dout)
    );

endmodule

//--- tb/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// One error counter per group of checks
int reset_errors   = 0;
int irq_errors     = 0;
int mailbox_errors = 0;
int split_errors   = 0;
int status_errors  = 0;

// Reset values while rst24 is held
reset_int1n_check: assert property (@(posedge clk) rst24 |-> int1n === 1'b1)
    else begin
        reset_errors++;
        $display("Mismatch at %0t: int1n expected 1 actual %b", $time, $sampled(int1n));
    end

reset_p0_in_check: assert property (@(posedge clk) rst24 |-> p0_in === '0)
    else begin
        reset_errors++;
        $display("Mismatch at %0t: p0_in expected 00 actual %h", $time, $sampled(p0_in));
    end

reset_mcu_dout_check: assert property (@(posedge clk) rst24 |-> mcu_dout === '0)
    else begin
        reset_errors++;
        $display("Mismatch at %0t: mcu_dout expected 0000 actual %h",
                 $time, $sampled(mcu_dout));
    end

reset_st_dout_check: assert property (@(posedge clk) rst24 |-> st_dout === '0)
    else begin
        reset_errors++;
        $display("Mismatch at %0t: st_dout expected 00 actual %h", $time, $sampled(st_dout));
    end

// Registered outputs against the reference model
int1n_check: assert property (@(posedge clk) disable iff (rst24) int1n == exp_int1n)
    else begin
        irq_errors++;
        $display("Mismatch at %0t: int1n expected %b actual %b",
                 $time, $sampled(exp_int1n), $sampled(int1n));
    end

p0_in_check: assert property (@(posedge clk) disable iff (rst24) p0_in == exp_p0_in)
    else begin
        mailbox_errors++;
        $display("Mismatch at %0t: p0_in expected %h actual %h",
                 $time, $sampled(exp_p0_in), $sampled(p0_in));
    end

mcu_dout_check: assert property (@(posedge clk) disable iff (rst24) mcu_dout == exp_mcu_dout)
    else begin
        mailbox_errors++;
        $display("Mismatch at %0t: mcu_dout expected %h actual %h",
                 $time, $sampled(exp_mcu_dout), $sampled(mcu_dout));
    end

st_dout_check: assert property (@(posedge clk) disable iff (rst24) st_dout == exp_st_dout)
    else begin
        status_errors++;
        $display("Mismatch at %0t: st_dout expected %h actual %h",
                 $time, $sampled(exp_st_dout), $sampled(st_dout));
    end

// Port splits with zero latency
snd_flag_check: assert property (@(posedge clk) snd_flag == p1_out[6:5])
    else begin
        split_errors++;
        $display("Mismatch at %0t: snd_flag expected %h actual %h",
                 $time, $sampled(p1_out[6:5]), $sampled(snd_flag));
    end

b1_flag_check: assert property (@(posedge clk) b1_flag == p1_out[4:3])
    else begin
        split_errors++;
        $display("Mismatch at %0t: b1_flag expected %h actual %h",
                 $time, $sampled(p1_out[4:3]), $sampled(b1_flag));
    end

b0_flag_check: assert property (@(posedge clk) b0_flag == p1_out[2])
    else begin
        split_errors++;
        $display("Mismatch at %0t: b0_flag expected %b actual %b",
                 $time, $sampled(p1_out[2]), $sampled(b0_flag));
    end

mix_flag_check: assert property (@(posedge clk) mix_flag == p1_out[1:0])
    else begin
        split_errors++;
        $display("Mismatch at %0t: mix_flag expected %h actual %h",
                 $time, $sampled(p1_out[1:0]), $sampled(mix_flag));
    end

crback_check: assert property (@(posedge clk) crback == p3_out[2:0])
    else begin
        split_errors++;
        $display("Mismatch at %0t: crback expected %h actual %h",
                 $time, $sampled(p3_out[2:0]), $sampled(crback));
    end

sel2_check: assert property (@(posedge clk) sel2 == p2_out[2])
    else begin
        split_errors++;
        $display("Mismatch at %0t: sel2 expected %b actual %b",
                 $time, $sampled(p2_out[2]), $sampled(sel2));
    end

// Select bits 5:3 above port 3's own low bits
p3_in_check: assert property (@(posedge clk) p3_in == {mcu_sel[5:3], p3_out[4:0]})
    else begin
        split_errors++;
        $display("Mismatch at %0t: p3_in expected %h actual %h",
                 $time, $sampled({mcu_sel[5:3], p3_out[4:0]}), $sampled(p3_in));
    end

`endif

//--- tb/tb_cop_mcu_bridge.sv
`timescale 1ns/1ps

module tb_cop_mcu_bridge
    import mcu_port_pkg::*, cop_bank_pkg::*;
();

    localparam int          TB_SYNC        = 1;
    localparam int          TIMEOUT_CYCLES = 2000;
    localparam int          IRQ_WAIT_LIMIT = 8;
    localparam int          READ_REPEATS   = 8;
    localparam int          WRITE_REPEATS  = 8;
    localparam int          RANDOM_CYCLES  = 200;
    localparam logic [31:0] SEED           = 32'h5459_6b32;
    // All port 2 strobes and the acknowledge inactive
    localparam port_byte_t  P2_IDLE        = 8'hFF;

    logic       clk = 1'b0;
    logic       rst24;
    mcu_sel_t   mcu_sel;
    mcu_word_t  mcu_din;
    port_byte_t p0_out;
    port_byte_t p1_out;
    port_byte_t p2_out;
    port_byte_t p3_out;
    port_byte_t st_addr;

    logic       int1n;
    port_byte_t p0_in;
    port_byte_t p3_in;
    mcu_word_t  mcu_dout;
    logic       sel2;
    snd_flag_t  snd_flag;
    b1_flag_t   b1_flag;
    logic       b0_flag;
    mix_flag_t  mix_flag;
    crback_t    crback;
    port_byte_t st_dout;

    // Reference model state
    logic       exp_int1n;
    port_byte_t exp_p0_in;
    mcu_word_t  exp_mcu_dout;
    port_byte_t exp_st_dout;
    logic       sel_prev;
    logic [3:0] rise_pipe;

    int cycle_count;
    int wait_errors = 0;
    int total_errors;

    cop_mcu_bridge #(
        .SYNC_STAGES (TB_SYNC)
    ) dut_i (
        .clk      (clk),
        .rst24    (rst24),
        .mcu_sel  (mcu_sel),
        .mcu_din  (mcu_din),
        .p0_out   (p0_out),
        .p1_out   (p1_out),
        .p2_out   (p2_out),
        .p3_out   (p3_out),
        .st_addr  (st_addr),
        .int1n    (int1n),
        .p0_in    (p0_in),
        .p3_in    (p3_in),
        .mcu_dout (mcu_dout),
        .sel2     (sel2),
        .snd_flag (snd_flag),
        .b1_flag  (b1_flag),
        .b0_flag  (b0_flag),
        .mix_flag (mix_flag),
        .crback   (crback),
        .st_dout  (st_dout)
    );

    always #10 clk = ~clk;

    // Expected registered outputs, from the values seen before each edge
    always @(posedge clk or posedge rst24) begin : ref_model
        logic     rise_now;
        logic     fire;
        st_page_t page;
        if (rst24) begin
            exp_int1n    <= 1'b1;
            exp_p0_in    <= '0;
            exp_mcu_dout <= '0;
            exp_st_dout  <= '0;
            sel_prev     <= 1'b0;
            rise_pipe    <= '0;
        end else begin
            // A high sample after a low one requests the interrupt TB_SYNC edges later
            rise_now = mcu_sel[SEL_IRQ_BIT] && !sel_prev;
            fire = (TB_SYNC == 0) ? rise_now : rise_pipe[TB_SYNC-1];
            sel_prev  <= mcu_sel[SEL_IRQ_BIT];
            rise_pipe <= {rise_pipe[2:0], rise_now};
            if (!p2_out[P2_ACK_BIT]) begin
                exp_int1n <= 1'b1;
            end else if (fire) begin
                exp_int1n <= 1'b0;
            end

            if (!p2_out[P2_RDLO_BIT]) begin
                exp_p0_in <= mcu_din[7:0];
            end else if (!p2_out[P2_RDHI_BIT]) begin
                exp_p0_in <= mcu_din[15:8];
            end
            if (!p2_out[P2_WRHI_BIT]) begin
                exp_mcu_dout[15:8] <= p0_out;
            end
            if (!p2_out[P2_WRLO_BIT]) begin
                exp_mcu_dout[7:0] <= p0_out;
            end

            page = st_addr[7:6];
            case (page)
                PAGE_DOUT_LO: exp_st_dout <= exp_mcu_dout[7:0];
                PAGE_DOUT_HI: exp_st_dout <= exp_mcu_dout[15:8];
                PAGE_P0_IN:   exp_st_dout <= exp_p0_in;
                PAGE_FLAGS:   exp_st_dout <= {1'b0, p1_out[6:0]};
                default:      exp_st_dout <= '0;
            endcase
        end
    end

    `include "tb_checks.svh"

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // Sampled on the falling edge, where int1n is settled
    task automatic wait_for_irq();
        int waited;
        waited = 0;
        @(negedge clk);
        while (int1n !== 1'b0 && waited < IRQ_WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (int1n !== 1'b0) begin
            wait_errors++;
            $display("int1n did not go low within %0d cycles of a select edge",
                     IRQ_WAIT_LIMIT);
        end
    endtask

    task automatic run_irq_tests();
        // Request, select held high, then acknowledge
        mcu_sel[SEL_IRQ_BIT] <= 1'b1;
        wait_for_irq();
        idle_cycles(5);
        p2_out[P2_ACK_BIT] <= 1'b0;
        @(posedge clk);
        p2_out[P2_ACK_BIT] <= 1'b1;
        mcu_sel[SEL_IRQ_BIT] <= 1'b0;
        idle_cycles(3);
        // Leave a request pending
        mcu_sel[SEL_IRQ_BIT] <= 1'b1;
        wait_for_irq();
        @(posedge clk);
        mcu_sel[SEL_IRQ_BIT] <= 1'b0;
        idle_cycles(3);
        // New edge detected on the same edge that samples the acknowledge
        mcu_sel[SEL_IRQ_BIT] <= 1'b1;
        @(posedge clk);
        p2_out[P2_ACK_BIT] <= 1'b0;
        @(posedge clk);
        p2_out[P2_ACK_BIT] <= 1'b1;
        idle_cycles(4);
        mcu_sel[SEL_IRQ_BIT] <= 1'b0;
        idle_cycles(3);
    endtask

    task automatic mailbox_read(input logic hi, input logic lo);
        logic [31:0] rnd;
        rnd = $urandom;
        mcu_din <= rnd[15:0];
        p2_out[P2_RDHI_BIT] <= ~hi;
        p2_out[P2_RDLO_BIT] <= ~lo;
        @(posedge clk);
        p2_out[P2_RDHI_BIT] <= 1'b1;
        p2_out[P2_RDLO_BIT] <= 1'b1;
        idle_cycles(1);
    endtask

    task automatic mailbox_write(input logic hi, input logic lo);
        logic [31:0] rnd;
        rnd = $urandom;
        p0_out <= rnd[7:0];
        p2_out[P2_WRHI_BIT] <= ~hi;
        p2_out[P2_WRLO_BIT] <= ~lo;
        @(posedge clk);
        p2_out[P2_WRHI_BIT] <= 1'b1;
        p2_out[P2_WRLO_BIT] <= 1'b1;
        idle_cycles(1);
    endtask

    task automatic read_status(input st_page_t page);
        logic [31:0] rnd;
        rnd = $urandom;
        st_addr <= {page, rnd[5:0]};
        p1_out  <= rnd[15:8];
        idle_cycles(2);
    endtask

    // Every input random, strobes and requests included
    task automatic random_ports(input int n);
        logic [31:0] rnd;
        repeat (n) begin
            rnd = $urandom;
            p1_out  <= rnd[7:0];
            p2_out  <= rnd[15:8];
            p3_out  <= rnd[23:16];
            mcu_sel <= rnd[29:24];
            rnd = $urandom;
            mcu_din <= rnd[15:0];
            p0_out  <= rnd[23:16];
            st_addr <= rnd[31:24];
            @(posedge clk);
        end
        p2_out  <= P2_IDLE;
        mcu_sel <= '0;
        @(posedge clk);
    endtask

    initial begin
        void'($urandom(SEED));
        rst24   <= 1'b1;
        mcu_sel <= '0;
        mcu_din <= '0;
        p0_out  <= '0;
        p1_out  <= '0;
        p2_out  <= P2_IDLE;
        p3_out  <= '0;
        st_addr <= '0;
        repeat (4) @(posedge clk);
        rst24 <= 1'b0;
        @(posedge clk);

        run_irq_tests();
        repeat (READ_REPEATS) begin
            mailbox_read(1'b1, 1'b0);
            mailbox_read(1'b0, 1'b1);
            mailbox_read(1'b1, 1'b1);
        end
        repeat (WRITE_REPEATS) begin
            mailbox_write(1'b1, 1'b0);
            mailbox_write(1'b0, 1'b1);
            mailbox_write(1'b1, 1'b1);
        end
        for (int pg = 0; pg < 4; pg++) begin
            repeat (3) read_status(st_page_t'(pg));
        end
        random_ports(RANDOM_CYCLES);
        idle_cycles(3);

        total_errors = reset_errors + irq_errors + mailbox_errors + split_errors
                     + status_errors + wait_errors;
        $display("Error counts: reset %0d, irq %0d, mailbox %0d, split %0d, status %0d, wait %0d",
                 reset_errors, irq_errors, mailbox_errors, split_errors,
                 status_errors, wait_errors);
        if (total_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+tb
common/mcu_port_pkg.sv
common/cop_bank_pkg.sv
mcu_bridge/sel_irq.sv
mcu_bridge/byte_mailbox.sv
logic/status_dump.sv
logic/cop_mcu_bridge.sv
tb/tb_cop_mcu_bridge.sv

//--- Makefile
# Verilator build and run of the COP MCU bridge testbench

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_cop_mcu_bridge
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := Regression passed

# Sources come from the file list, headers from the include folder
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard tb/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message appears on a line of its own
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
